// ==== logic/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int ID_W   = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [2:0]        size_t;
    typedef logic [ID_W-1:0]   id_t;

    // bit 0 of the read id selects the returning cache
    localparam id_t INST_RD_ID = 4'd0;
    localparam id_t DATA_RD_ID = 4'd1;

    // cache side requests
    typedef struct packed {
        addr_t addr;
        size_t size;
    } cache_rd_req_t;

    typedef struct packed {
        addr_t addr;
        size_t size;
        strb_t strb;
        data_t data;
    } cache_wr_req_t;

    // axi read address
    typedef struct packed {
        id_t   id;
        addr_t addr;
        size_t size;
    } axi_ar_t;

    // single beat axi read data
    typedef struct packed {
        id_t   id;
        data_t data;
    } axi_r_t;

    // axi write address
    typedef struct packed {
        addr_t addr;
        size_t size;
    } axi_aw_t;

    // axi write data
    typedef struct packed {
        data_t data;
        strb_t strb;
    } axi_w_t;

endpackage

// ==== logic/cache_rd_port.sv ====
module cache_rd_port #(
    parameter axi_bridge_pkg::id_t PORT_ID = axi_bridge_pkg::INST_RD_ID
) (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          rd_req_i,
    input  axi_bridge_pkg::cache_rd_req_t rd_i,
    input  logic                          grant_i,
    input  logic                          arready_i,
    input  axi_bridge_pkg::axi_r_t        r_i,
    input  logic                          rvalid_i,
    output logic                          rd_rdy_o,
    output axi_bridge_pkg::axi_ar_t       ar_o,
    output logic                          arvalid_o,
    output logic                          rready_o,
    output logic                          in_data_phase_o,
    output logic                          idle_o,
    output logic                          ret_valid_o,
    output axi_bridge_pkg::data_t         ret_data_o
);

    typedef enum logic [1:0] {
        R_FREE,
        R_ADDR,
        R_DATA
    } rd_state_t;

    rd_state_t state_q;
    logic      accept;
    logic      ar_done;
    logic      r_done;

    assign idle_o          = (state_q == R_FREE);
    assign in_data_phase_o = (state_q == R_DATA);

    // a request is taken only when the mux grants this port
    assign rd_rdy_o = idle_o && grant_i;
    assign accept   = rd_req_i && rd_rdy_o;

    assign arvalid_o = (state_q == R_ADDR);
    assign rready_o  = (state_q == R_DATA);

    assign ar_done = arvalid_o && arready_i;
    assign r_done  = rvalid_i && rready_o;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= R_FREE;
        end else begin
            case (state_q)
                R_FREE: begin
                    if (accept) begin
                        state_q <= R_ADDR;
                    end
                end
                R_ADDR: begin
                    if (ar_done) begin
                        state_q <= R_DATA;
                    end
                end
                R_DATA: begin
                    if (r_done) begin
                        state_q <= R_FREE;
                    end
                end
                default: begin
                    state_q <= R_FREE;
                end
            endcase
        end
    end

    // ar payload held until the handshake
    always_ff @(posedge aclk) begin
        if (accept) begin
            ar_o.id   <= PORT_ID;
            ar_o.addr <= rd_i.addr;
            ar_o.size <= rd_i.size;
        end
    end

    always_ff @(posedge aclk) begin
        if (r_done) begin
            ret_data_o <= r_i.data;
        end
    end

    // one cycle pulse after the r handshake
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ret_valid_o <= 1'b0;
        end else begin
            ret_valid_o <= r_done;
        end
    end

endmodule

// ==== logic/cpu_axi_bridge.sv ====
module cpu_axi_bridge (
    input  logic                          aclk,
    input  logic                          aresetn,

    input  logic                          icache_rd_req_i,
    input  axi_bridge_pkg::cache_rd_req_t icache_rd_i,
    output logic                          icache_rd_rdy_o,
    output logic                          icache_ret_valid_o,
    output axi_bridge_pkg::data_t         icache_ret_data_o,

    input  logic                          dcache_rd_req_i,
    input  axi_bridge_pkg::cache_rd_req_t dcache_rd_i,
    output logic                          dcache_rd_rdy_o,
    output logic                          dcache_ret_valid_o,
    output axi_bridge_pkg::data_t         dcache_ret_data_o,

    input  logic                          dcache_wr_req_i,
    input  axi_bridge_pkg::cache_wr_req_t dcache_wr_i,
    output logic                          dcache_wr_rdy_o,
    output logic                          dcache_wr_ok_o,

    output axi_bridge_pkg::axi_ar_t       m_ar_o,
    output logic                          m_arvalid_o,
    input  logic                          m_arready_i,
    input  axi_bridge_pkg::axi_r_t        m_r_i,
    input  logic                          m_rvalid_i,
    output logic                          m_rready_o,
    output axi_bridge_pkg::axi_aw_t       m_aw_o,
    output logic                          m_awvalid_o,
    input  logic                          m_awready_i,
    output axi_bridge_pkg::axi_w_t        m_w_o,
    output logic                          m_wvalid_o,
    input  logic                          m_wready_i,
    input  logic                          m_bvalid_i,
    output logic                          m_bready_o
);
    import axi_bridge_pkg::*;

    logic    i_grant;
    logic    d_grant;
    logic    i_idle;
    logic    d_idle;
    logic    d_data_phase;
    axi_ar_t i_ar;
    axi_ar_t d_ar;
    logic    i_arvalid;
    logic    d_arvalid;
    logic    i_rready;
    logic    d_rready;
    logic    i_rvalid;
    logic    d_rvalid;
    logic    wr_busy;

    // instruction side with id bit 0 clear
    cache_rd_port #(
        .PORT_ID(INST_RD_ID)
    ) u_icache_port (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .rd_req_i        (icache_rd_req_i),
        .rd_i            (icache_rd_i),
        .grant_i         (i_grant),
        .arready_i       (m_arready_i),
        .r_i             (m_r_i),
        .rvalid_i        (i_rvalid),
        .rd_rdy_o        (icache_rd_rdy_o),
        .ar_o            (i_ar),
        .arvalid_o       (i_arvalid),
        .rready_o        (i_rready),
        .in_data_phase_o (),
        .idle_o          (i_idle),
        .ret_valid_o     (icache_ret_valid_o),
        .ret_data_o      (icache_ret_data_o)
    );

    cache_rd_port #(
        .PORT_ID(DATA_RD_ID)
    ) u_dcache_port (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .rd_req_i        (dcache_rd_req_i),
        .rd_i            (dcache_rd_i),
        .grant_i         (d_grant),
        .arready_i       (m_arready_i),
        .r_i             (m_r_i),
        .rvalid_i        (d_rvalid),
        .rd_rdy_o        (dcache_rd_rdy_o),
        .ar_o            (d_ar),
        .arvalid_o       (d_arvalid),
        .rready_o        (d_rready),
        .in_data_phase_o (d_data_phase),
        .idle_o          (d_idle),
        .ret_valid_o     (dcache_ret_valid_o),
        .ret_data_o      (dcache_ret_data_o)
    );

    rd_channel_mux u_rd_mux (
        .icache_req_i   (icache_rd_req_i),
        .dcache_req_i   (dcache_rd_req_i),
        .i_idle_i       (i_idle),
        .d_idle_i       (d_idle),
        .d_data_phase_i (d_data_phase),
        .wr_busy_i      (wr_busy),
        .i_ar_i         (i_ar),
        .d_ar_i         (d_ar),
        .i_arvalid_i    (i_arvalid),
        .d_arvalid_i    (d_arvalid),
        .i_rready_i     (i_rready),
        .d_rready_i     (d_rready),
        .m_r_i          (m_r_i),
        .m_rvalid_i     (m_rvalid_i),
        .i_grant_o      (i_grant),
        .d_grant_o      (d_grant),
        .m_ar_o         (m_ar_o),
        .m_arvalid_o    (m_arvalid_o),
        .m_rready_o     (m_rready_o),
        .i_rvalid_o     (i_rvalid),
        .d_rvalid_o     (d_rvalid)
    );

    dcache_wr_engine u_wr_engine (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .wr_req_i    (dcache_wr_req_i),
        .wr_i        (dcache_wr_i),
        .m_awready_i (m_awready_i),
        .m_wready_i  (m_wready_i),
        .m_bvalid_i  (m_bvalid_i),
        .wr_rdy_o    (dcache_wr_rdy_o),
        .wr_ok_o     (dcache_wr_ok_o),
        .wr_busy_o   (wr_busy),
        .m_aw_o      (m_aw_o),
        .m_awvalid_o (m_awvalid_o),
        .m_w_o       (m_w_o),
        .m_wvalid_o  (m_wvalid_o),
        .m_bready_o  (m_bready_o)
    );

endmodule

// ==== logic/dcache_wr_engine.sv ====
module dcache_wr_engine (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          wr_req_i,
    input  axi_bridge_pkg::cache_wr_req_t wr_i,
    input  logic                          m_awready_i,
    input  logic                          m_wready_i,
    input  logic                          m_bvalid_i,
    output logic                          wr_rdy_o,
    output logic                          wr_ok_o,
    output logic                          wr_busy_o,
    output axi_bridge_pkg::axi_aw_t       m_aw_o,
    output logic                          m_awvalid_o,
    output axi_bridge_pkg::axi_w_t        m_w_o,
    output logic                          m_wvalid_o,
    output logic                          m_bready_o
);

    typedef enum logic [1:0] {
        W_FREE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_t;

    wr_state_t state_q;
    logic      accept;
    logic      aw_done;
    logic      w_done;
    logic      b_done;

    assign wr_rdy_o = (state_q == W_FREE);
    assign accept   = wr_req_i && wr_rdy_o;

    // also high in the request cycle, so the read mux holds off at once
    assign wr_busy_o = wr_req_i || (state_q != W_FREE);

    assign m_awvalid_o = (state_q == W_ADDR);
    assign m_wvalid_o  = (state_q == W_DATA);
    assign m_bready_o  = (state_q == W_DATA) || (state_q == W_RESP);

    assign aw_done = m_awvalid_o && m_awready_i;
    assign w_done  = m_wvalid_o && m_wready_i;

    // B only counts once W is through
    assign b_done = (state_q == W_RESP) && m_bvalid_i;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= W_FREE;
        end else begin
            case (state_q)
                W_FREE: begin
                    if (accept) begin
                        state_q <= W_ADDR;
                    end
                end
                W_ADDR: begin
                    if (aw_done) begin
                        state_q <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (w_done) begin
                        state_q <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (b_done) begin
                        state_q <= W_FREE;
                    end
                end
                default: begin
                    state_q <= W_FREE;
                end
            endcase
        end
    end

    // request buffered for the whole transfer
    always_ff @(posedge aclk) begin
        if (accept) begin
            m_aw_o.addr <= wr_i.addr;
            m_aw_o.size <= wr_i.size;
            m_w_o.data  <= wr_i.data;
            m_w_o.strb  <= wr_i.strb;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ok_o <= 1'b0;
        end else begin
            wr_ok_o <= b_done;
        end
    end

endmodule

// ==== logic/rd_channel_mux.sv ====
module rd_channel_mux (
    input  logic                    icache_req_i,
    input  logic                    dcache_req_i,
    input  logic                    i_idle_i,
    input  logic                    d_idle_i,
    input  logic                    d_data_phase_i,
    input  logic                    wr_busy_i,
    input  axi_bridge_pkg::axi_ar_t i_ar_i,
    input  axi_bridge_pkg::axi_ar_t d_ar_i,
    input  logic                    i_arvalid_i,
    input  logic                    d_arvalid_i,
    input  logic                    i_rready_i,
    input  logic                    d_rready_i,
    input  axi_bridge_pkg::axi_r_t  m_r_i,
    input  logic                    m_rvalid_i,
    output logic                    i_grant_o,
    output logic                    d_grant_o,
    output axi_bridge_pkg::axi_ar_t m_ar_o,
    output logic                    m_arvalid_o,
    output logic                    m_rready_o,
    output logic                    i_rvalid_o,
    output logic                    d_rvalid_o
);
    import axi_bridge_pkg::*;

    logic rd_allowed;
    logic d_past_ar;
    logic r_to_data;

    // no new read while a write is pending or in flight
    assign rd_allowed = !wr_busy_i;

    // data read wins, but waits for an outstanding instruction read
    assign d_grant_o = dcache_req_i && d_idle_i && i_idle_i && rd_allowed;

    // the instruction read may overlap a data read that has left AR
    assign d_past_ar = d_data_phase_i || (d_idle_i && !dcache_req_i);
    assign i_grant_o = icache_req_i && i_idle_i && d_past_ar && rd_allowed;

    // only one port has arvalid at a time
    always_comb begin
        if (d_arvalid_i) begin
            m_ar_o = d_ar_i;
        end else begin
            m_ar_o = i_ar_i;
        end
    end

    assign m_arvalid_o = i_arvalid_i || d_arvalid_i;

    // return routing by id bit 0
    assign r_to_data  = (m_r_i.id[0] == DATA_RD_ID[0]);
    assign d_rvalid_o = m_rvalid_i && r_to_data;
    assign i_rvalid_o = m_rvalid_i && (m_r_i.id[0] == INST_RD_ID[0]);

    assign m_rready_o = i_rready_i || d_rready_i;

endmodule

// ==== sim/cpu_axi_bridge_chk.sv ====
module cpu_axi_bridge_chk (
    input logic                    aclk,
    input logic                    aresetn,
    input axi_bridge_pkg::axi_ar_t m_ar_o,
    input logic                    m_arvalid_o,
    input logic                    m_arready_i,
    input axi_bridge_pkg::axi_aw_t m_aw_o,
    input logic                    m_awvalid_o,
    input logic                    m_awready_i,
    input axi_bridge_pkg::axi_w_t  m_w_o,
    input logic                    m_wvalid_o,
    input logic                    m_wready_i,
    input logic                    m_rready_o,
    input logic                    m_bready_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int error_count = 0;

    // valid and payload held until ready
    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_ar_o))
        else begin
            $error("AR valid or payload changed before arready");
            error_count++;
        end

    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_aw_o))
        else begin
            $error("AW valid or payload changed before awready");
            error_count++;
        end

    w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_w_o))
        else begin
            $error("W valid or payload changed before wready");
            error_count++;
        end

    // reads stay blocked while a write waits for B
    no_ar_in_write: assert property (@(posedge aclk) disable iff (!aresetn)
        m_bready_o |-> !$rose(m_arvalid_o))
        else begin
            $error("arvalid rose while a write response was awaited");
            error_count++;
        end

    quiet_after_reset: assert property (@(posedge aclk)
        !aresetn |=> !m_arvalid_o && !m_awvalid_o && !m_wvalid_o && !m_rready_o && !m_bready_o)
        else begin
            $error("bus valid or ready output high right after reset");
            error_count++;
        end

endmodule

bind cpu_axi_bridge cpu_axi_bridge_chk u_chk (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .m_ar_o      (m_ar_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_aw_o      (m_aw_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_w_o       (m_w_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_rready_o  (m_rready_o),
    .m_bready_o  (m_bready_o)
);

// ==== sim/tb_cpu_axi_bridge.sv ====
module tb_cpu_axi_bridge;
    timeunit 1ns;
    timeprecision 1ps;
    import axi_bridge_pkg::*;

    localparam int          NUM_OPS    = 300;
    localparam int          MAX_CYCLES = NUM_OPS * 30 + 3000;
    localparam logic [31:0] SEED       = 32'ha193_5812;

    logic          aclk;
    logic          aresetn;
    logic          icache_rd_req_i;
    cache_rd_req_t icache_rd_i;
    logic          icache_rd_rdy_o;
    logic          icache_ret_valid_o;
    data_t         icache_ret_data_o;
    logic          dcache_rd_req_i;
    cache_rd_req_t dcache_rd_i;
    logic          dcache_rd_rdy_o;
    logic          dcache_ret_valid_o;
    data_t         dcache_ret_data_o;
    logic          dcache_wr_req_i;
    cache_wr_req_t dcache_wr_i;
    logic          dcache_wr_rdy_o;
    logic          dcache_wr_ok_o;
    axi_ar_t       m_ar_o;
    logic          m_arvalid_o;
    logic          m_arready_i;
    axi_r_t        m_r_i;
    logic          m_rvalid_i;
    logic          m_rready_o;
    axi_aw_t       m_aw_o;
    logic          m_awvalid_o;
    logic          m_awready_i;
    axi_w_t        m_w_o;
    logic          m_wvalid_o;
    logic          m_wready_i;
    logic          m_bvalid_i;
    logic          m_bready_o;

    logic [31:0]   drv_rng;
    axi_ar_t       exp_ar[$];
    addr_t         exp_i[$];
    addr_t         exp_d[$];
    cache_wr_req_t exp_wr[$];
    int            b_count = 0;
    logic          wr_active = 1'b0;
    time           i_acc_t;
    time           d_acc_t;

    cpu_axi_bridge UUT (.*);

    // xor with a constant, then rotate left by 11
    function automatic data_t mem_word(input addr_t a);
        data_t x;
        x = a ^ 32'h5ac3_1e97;
        return {x[20:0], x[31:21]};
    endfunction

    function automatic logic [31:0] next_random(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    function automatic int pick(inout logic [31:0] state, input int n);
        logic [31:0] r;
        r = next_random(state);
        return int'(r[31:16]) % n;
    endfunction

    task automatic report_and_stop(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    initial begin
        aclk = 1'b0;
        forever begin
            #10 aclk = ~aclk;
        end
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $fatal(1);
    end

    task automatic icache_read(input addr_t a, input size_t s);
        @(negedge aclk);
        icache_rd_req_i = 1'b1;
        icache_rd_i     = '{addr: a, size: s};
        do @(posedge aclk); while (!icache_rd_rdy_o);
        exp_ar.push_back(axi_ar_t'{id: 4'h0, addr: a, size: s});
        exp_i.push_back(a);
        i_acc_t = $time;
        @(negedge aclk);
        icache_rd_req_i = 1'b0;
        do @(posedge aclk); while (!icache_ret_valid_o);
    endtask

    task automatic dcache_read(input addr_t a, input size_t s);
        @(negedge aclk);
        dcache_rd_req_i = 1'b1;
        dcache_rd_i     = '{addr: a, size: s};
        do @(posedge aclk); while (!dcache_rd_rdy_o);
        exp_ar.push_back(axi_ar_t'{id: 4'h1, addr: a, size: s});
        exp_d.push_back(a);
        d_acc_t = $time;
        @(negedge aclk);
        dcache_rd_req_i = 1'b0;
        do @(posedge aclk); while (!dcache_ret_valid_o);
    endtask

    task automatic dcache_write(input cache_wr_req_t w);
        @(negedge aclk);
        dcache_wr_req_i = 1'b1;
        dcache_wr_i     = w;
        do @(posedge aclk); while (!dcache_wr_rdy_o);
        exp_wr.push_back(w);
        @(negedge aclk);
        dcache_wr_req_i = 1'b0;
        do @(posedge aclk); while (!dcache_wr_ok_o);
    endtask

    // op kind 0 iread, 1 dread, 2 both reads, 3 write, 4 write with iread, 5 write with dread
    task automatic run_op(input int kind);
        addr_t         a0;
        addr_t         a1;
        size_t         s0;
        size_t         s1;
        cache_wr_req_t w;
        a0     = next_random(drv_rng) & 32'hffff_fffc;
        a1     = next_random(drv_rng) & 32'hffff_fffc;
        s0     = size_t'(pick(drv_rng, 3));
        s1     = size_t'(pick(drv_rng, 3));
        w.addr = next_random(drv_rng) & 32'hffff_fffc;
        w.size = size_t'(pick(drv_rng, 3));
        w.strb = strb_t'(pick(drv_rng, 15) + 1);
        w.data = next_random(drv_rng);
        case (kind)
            0: icache_read(a0, s0);
            1: dcache_read(a1, s1);
            2: begin
                fork
                    icache_read(a0, s0);
                    dcache_read(a1, s1);
                join
                assert (d_acc_t < i_acc_t)
                    else report_and_stop("Simultaneous reads: data read was not granted first");
            end
            3: dcache_write(w);
            4: begin
                fork
                    dcache_write(w);
                    icache_read(a0, s0);
                join
            end
            default: begin
                fork
                    dcache_write(w);
                    dcache_read(a1, s1);
                join
            end
        endcase
    endtask

    // reads are answered in order
    initial begin : slave_model
        axi_ar_t     rd_q[$];
        int          dly[5];
        int          b_pend;
        logic [4:0]  fired;
        logic [4:0]  waiting;
        logic [31:0] slave_rng;
        slave_rng   = {SEED[15:0], SEED[31:16]};
        b_pend      = 0;
        dly         = '{0, 0, 0, 0, 0};
        m_arready_i = 1'b0;
        m_rvalid_i  = 1'b0;
        m_r_i       = '0;
        m_awready_i = 1'b0;
        m_wready_i  = 1'b0;
        m_bvalid_i  = 1'b0;
        forever begin
            @(posedge aclk);
            fired = {m_bvalid_i && m_bready_o, m_wvalid_o && m_wready_i,
                     m_awvalid_o && m_awready_i, m_rvalid_i && m_rready_o,
                     m_arvalid_o && m_arready_i};
            if (fired[0]) rd_q.push_back(m_ar_o);
            if (fired[1]) void'(rd_q.pop_front());
            if (fired[3]) b_pend++;
            if (fired[4]) b_pend--;
            waiting = {b_pend > 0, m_wvalid_o, m_awvalid_o, rd_q.size() > 0, m_arvalid_o};
            // stall of 0 to 3 cycles per transfer
            for (int c = 0; c < 5; c++) begin
                if (fired[c]) dly[c] = pick(slave_rng, 4);
                else if (waiting[c] && dly[c] > 0) dly[c]--;
            end
            @(negedge aclk);
            m_arready_i = (dly[0] == 0);
            m_awready_i = (dly[2] == 0);
            m_wready_i  = (dly[3] == 0);
            m_bvalid_i  = (b_pend > 0) && (dly[4] == 0);
            m_rvalid_i  = (rd_q.size() > 0) && (dly[1] == 0);
            m_r_i       = '0;
            if (m_rvalid_i) m_r_i = '{id: rd_q[0].id, data: mem_word(rd_q[0].addr)};
        end
    end

    always @(posedge aclk) begin : compare
        axi_ar_t ar_exp;
        addr_t   a;
        if (aresetn) begin
            assert (UUT.u_chk.error_count == 0)
                else report_and_stop("A protocol assertion in the bound checker failed");
            if (m_arvalid_o && m_arready_i) begin
                assert (!wr_active)
                    else report_and_stop("AR handshake while a write was in progress");
                assert (exp_ar.size() > 0)
                    else report_and_stop("AR handshake with no read request accepted");
                ar_exp = exp_ar.pop_front();
                assert (m_ar_o.id[0] == ar_exp.id[0]) else report_and_stop($sformatf(
                    "Error: m_ar_o.id[0] expected %h got %h", ar_exp.id[0], m_ar_o.id[0]));
                assert (m_ar_o.addr == ar_exp.addr) else report_and_stop($sformatf(
                    "Error: m_ar_o.addr expected %h got %h", ar_exp.addr, m_ar_o.addr));
                assert (m_ar_o.size == ar_exp.size) else report_and_stop($sformatf(
                    "Error: m_ar_o.size expected %h got %h", ar_exp.size, m_ar_o.size));
            end
            if (dcache_wr_req_i && dcache_wr_rdy_o) wr_active = 1'b1;
            if ((m_awvalid_o && m_awready_i) || (m_wvalid_o && m_wready_i)) begin
                assert (exp_wr.size() > 0)
                    else report_and_stop("Write transfer on the bus with no write accepted");
            end
            if (m_awvalid_o && m_awready_i) begin
                assert (m_aw_o.addr == exp_wr[0].addr) else report_and_stop($sformatf(
                    "Error: m_aw_o.addr expected %h got %h", exp_wr[0].addr, m_aw_o.addr));
                assert (m_aw_o.size == exp_wr[0].size) else report_and_stop($sformatf(
                    "Error: m_aw_o.size expected %h got %h", exp_wr[0].size, m_aw_o.size));
            end
            if (m_wvalid_o && m_wready_i) begin
                assert (m_w_o.data == exp_wr[0].data) else report_and_stop($sformatf(
                    "Error: m_w_o.data expected %h got %h", exp_wr[0].data, m_w_o.data));
                assert (m_w_o.strb == exp_wr[0].strb) else report_and_stop($sformatf(
                    "Error: m_w_o.strb expected %h got %h", exp_wr[0].strb, m_w_o.strb));
                void'(exp_wr.pop_front());
            end
            if (m_bvalid_i && m_bready_o) b_count++;
            if (dcache_wr_ok_o) begin
                assert (b_count > 0)
                    else report_and_stop("dcache_wr_ok_o pulsed without a B handshake");
                b_count--;
                wr_active = 1'b0;
            end
            if (icache_ret_valid_o) begin
                assert (exp_i.size() > 0)
                    else report_and_stop("icache return with no read outstanding");
                a = exp_i.pop_front();
                assert (icache_ret_data_o == mem_word(a)) else report_and_stop($sformatf(
                    "Error: icache_ret_data_o expected %h got %h", mem_word(a),
                    icache_ret_data_o));
            end
            if (dcache_ret_valid_o) begin
                assert (exp_d.size() > 0)
                    else report_and_stop("dcache return with no read outstanding");
                a = exp_d.pop_front();
                assert (dcache_ret_data_o == mem_word(a)) else report_and_stop($sformatf(
                    "Error: dcache_ret_data_o expected %h got %h", mem_word(a),
                    dcache_ret_data_o));
            end
        end
    end

    initial begin
        aresetn         = 1'b0;
        icache_rd_req_i = 1'b0;
        icache_rd_i     = '0;
        dcache_rd_req_i = 1'b0;
        dcache_rd_i     = '0;
        dcache_wr_req_i = 1'b0;
        dcache_wr_i     = '0;
        drv_rng         = SEED;
        repeat (4) @(negedge aclk);
        aresetn = 1'b1;
        // first six ops walk every kind once
        for (int op = 0; op < NUM_OPS; op++) begin
            if (op < 6) run_op(op);
            else run_op(pick(drv_rng, 6));
        end
        repeat (4) @(posedge aclk);
        if (exp_ar.size() == 0 && exp_i.size() == 0 && exp_d.size() == 0 &&
            exp_wr.size() == 0 && b_count == 0 && UUT.u_chk.error_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_and_stop("Transactions left open or a protocol assertion failed");
        end
    end

endmodule

// ==== sources.f ====
logic/axi_bridge_pkg.sv
logic/cache_rd_port.sv
logic/rd_channel_mux.sv
logic/dcache_wr_engine.sv
logic/cpu_axi_bridge.sv
sim/cpu_axi_bridge_chk.sv
sim/tb_cpu_axi_bridge.sv
